//--- conv_pkg.sv
package conv_pkg;

    // operand and memory geometry
    localparam int DATA_W     = 8;
    localparam int WORD_BYTES = 8;
    localparam int MAC_LANES  = 64;
    localparam int MAX_GROUPS = 8;
    localparam int WBUF_WORDS = 64;
    localparam int BUF_IDX_W  = $clog2(WBUF_WORDS);

    typedef logic [DATA_W-1:0]            byte_t;
    typedef logic [WORD_BYTES*DATA_W-1:0] word_t;
    typedef logic [7:0]                   dim_t;
    typedef logic [3:0]                   stride_t;
    typedef logic [15:0]                  addr_t;
    typedef logic [3:0]                   chan_t;
    typedef logic [6:0]                   mac_count_t;
    typedef logic [3:0]                   group_count_t;
    typedef logic [MAC_LANES*DATA_W-1:0]  lanes_t;
    typedef logic [MAX_GROUPS*$bits(mac_count_t)-1:0] mac_counts_t;

    // slot index into the patch or weight store, one bit above the store index
    typedef logic [BUF_IDX_W:0] slot_t;

    typedef struct packed {
        dim_t    img_row;
        dim_t    img_col;
        dim_t    ker_row;
        dim_t    ker_col;
        chan_t   in_channel;
        chan_t   out_channel;
        stride_t stride_row;
        stride_t stride_col;
    } conv_cfg_t;

    typedef struct packed {
        dim_t         out_row;
        dim_t         out_col;
        dim_t         ker_area;
        mac_count_t   total_macs;
        group_count_t groups_max;
    } conv_shape_t;

    typedef struct packed {
        logic  rd;
        addr_t addr;
    } mem_req_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_WEIGHTS,
        LOAD_PATCH,
        ISSUE,
        DONE
    } feed_state_e;

endpackage

//--- conv_shape.sv
`timescale 1ns/1ns

module conv_shape (
    input  conv_pkg::conv_cfg_t   cfg_i,
    output conv_pkg::conv_shape_t shape_o
);
    import conv_pkg::*;

    stride_t     stride_r;
    stride_t     stride_c;
    dim_t        area;
    logic [11:0] macs_wide;
    logic [11:0] groups_full;

    always_comb begin
        // a cleared configuration carries zero strides
        stride_r = (cfg_i.stride_row == '0) ? stride_t'(1) : cfg_i.stride_row;
        stride_c = (cfg_i.stride_col == '0) ? stride_t'(1) : cfg_i.stride_col;

        // valid convolution, no padding
        shape_o.out_row = (cfg_i.img_row - cfg_i.ker_row) / dim_t'(stride_r) + dim_t'(1);
        shape_o.out_col = (cfg_i.img_col - cfg_i.ker_col) / dim_t'(stride_c) + dim_t'(1);

        area             = cfg_i.ker_row * cfg_i.ker_col;
        macs_wide        = 12'(area) * 12'(cfg_i.in_channel);
        shape_o.ker_area = area;
        shape_o.total_macs = mac_count_t'(macs_wide);

        // as many whole groups as fit into the lanes
        if (macs_wide == '0) begin
            groups_full = '0;
        end else begin
            groups_full = 12'(MAC_LANES) / macs_wide;
        end

        if (groups_full > 12'(MAX_GROUPS)) begin
            shape_o.groups_max = group_count_t'(MAX_GROUPS);
        end else begin
            shape_o.groups_max = group_count_t'(groups_full);
        end
    end

    // checked once a configuration with channels has been latched
    always_comb begin
        if (cfg_i.in_channel != '0) begin
            a_macs_fit: assert (macs_wide <= 12'(MAC_LANES))
                else $error("patch of %0d bytes exceeds the MAC lanes", macs_wide);
            a_chan_fit: assert (cfg_i.in_channel <= chan_t'(WORD_BYTES))
                else $error("%0d input channels exceed one word", cfg_i.in_channel);
        end
    end

endmodule

//--- conv_ctrl.sv
`timescale 1ns/1ns

module conv_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   init_i,
    input  logic                   start_i,
    input  conv_pkg::conv_cfg_t    cfg_i,
    input  conv_pkg::conv_shape_t  shape_i,
    output conv_pkg::conv_cfg_t    cfg_o,
    output conv_pkg::mem_req_t     img_req_o,
    output conv_pkg::mem_req_t     wgt_req_o,
    output logic                   patch_wr_o,
    output conv_pkg::slot_t        patch_slot_o,
    output logic                   wgt_wr_o,
    output conv_pkg::slot_t        wgt_slot_o,
    output conv_pkg::chan_t        oc_base_o,
    output conv_pkg::group_count_t batch_groups_o,
    output conv_pkg::mac_counts_t  num_macs_o,
    output logic                   mac_valid_o,
    output conv_pkg::dim_t         conv_row_o,
    output conv_pkg::dim_t         conv_col_o,
    output logic                   busy_o,
    output logic                   done_o
);
    import conv_pkg::*;

    feed_state_e  state;
    feed_state_e  state_nxt;
    conv_cfg_t    cfg_q;
    slot_t        load_cnt;
    slot_t        slot_q;
    dim_t         ker_r;
    dim_t         ker_c;
    dim_t         out_r;
    dim_t         out_c;
    dim_t         win_row;
    dim_t         win_col;
    chan_t        oc_base;
    chan_t        oc_left;
    group_count_t batch_groups;
    logic [11:0]  wgt_total;
    logic         wgt_last;
    logic         patch_last;
    logic         row_last;
    logic         col_last;
    logic         batch_last;

    // weight word address equals the linear buffer slot
    assign wgt_total  = 12'(cfg_q.out_channel) * 12'(shape_i.ker_area);
    assign wgt_last   = (12'(load_cnt) == wgt_total);
    assign patch_last = ({1'b0, load_cnt} == shape_i.ker_area);

    // window origin in image coordinates
    assign win_row  = out_r * dim_t'(cfg_q.stride_row);
    assign win_col  = out_c * dim_t'(cfg_q.stride_col);
    assign row_last = (out_r == shape_i.out_row - dim_t'(1));
    assign col_last = (out_c == shape_i.out_col - dim_t'(1));

    assign oc_left      = cfg_q.out_channel - oc_base;
    assign batch_groups = (shape_i.groups_max < oc_left) ? shape_i.groups_max : oc_left;
    assign batch_last   = (batch_groups == oc_left);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (start_i) begin
                    state_nxt = LOAD_WEIGHTS;
                end
            end
            LOAD_WEIGHTS: begin
                if (wgt_last) begin
                    state_nxt = LOAD_PATCH;
                end
            end
            LOAD_PATCH: begin
                if (patch_last) begin
                    state_nxt = ISSUE;
                end
            end
            ISSUE: begin
                if (batch_last) begin
                    state_nxt = (row_last && col_last) ? DONE : LOAD_PATCH;
                end
            end
            DONE: state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst || init_i) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            cfg_q <= '0;
        end else if (state == IDLE && start_i && !init_i) begin
            cfg_q <= cfg_i;
        end
    end

    // slot, kernel position, window and channel counters
    always_ff @(posedge clk) begin
        if (!rst || init_i) begin
            load_cnt <= '0;
            ker_r    <= '0;
            ker_c    <= '0;
            out_r    <= '0;
            out_c    <= '0;
            oc_base  <= '0;
        end else begin
            case (state)
                LOAD_WEIGHTS: load_cnt <= wgt_last ? '0 : load_cnt + slot_t'(1);
                LOAD_PATCH: begin
                    if (patch_last) begin
                        load_cnt <= '0;
                        ker_r    <= '0;
                        ker_c    <= '0;
                    end else begin
                        load_cnt <= load_cnt + slot_t'(1);
                        if (ker_c == cfg_q.ker_col - dim_t'(1)) begin
                            ker_c <= '0;
                            ker_r <= ker_r + dim_t'(1);
                        end else begin
                            ker_c <= ker_c + dim_t'(1);
                        end
                    end
                end
                ISSUE: begin
                    if (batch_last) begin
                        oc_base <= '0;
                        if (col_last) begin
                            out_c <= '0;
                            out_r <= row_last ? '0 : out_r + dim_t'(1);
                        end else begin
                            out_c <= out_c + dim_t'(1);
                        end
                    end else begin
                        oc_base <= oc_base + batch_groups;
                    end
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        wgt_req_o.rd   = (state == LOAD_WEIGHTS) && !wgt_last;
        wgt_req_o.addr = addr_t'(load_cnt);
        img_req_o.rd   = (state == LOAD_PATCH) && !patch_last;
        img_req_o.addr = addr_t'(win_row + ker_r) * addr_t'(cfg_q.img_col)
                       + addr_t'(win_col + ker_c);
    end

    // returned words land one cycle after their request
    always_ff @(posedge clk) begin
        if (!rst || init_i) begin
            patch_wr_o <= 1'b0;
            wgt_wr_o   <= 1'b0;
        end else begin
            patch_wr_o <= img_req_o.rd;
            wgt_wr_o   <= wgt_req_o.rd;
        end
    end

    always_ff @(posedge clk) begin
        slot_q <= load_cnt;
    end

    always_comb begin
        num_macs_o = '0;
        for (int g = 0; g < MAX_GROUPS; g++) begin
            if (g < int'(batch_groups)) begin
                num_macs_o[g*$bits(mac_count_t) +: $bits(mac_count_t)] = shape_i.total_macs;
            end
        end
    end

    assign cfg_o          = cfg_q;
    assign patch_slot_o   = slot_q;
    assign wgt_slot_o     = slot_q;
    assign oc_base_o      = oc_base;
    assign batch_groups_o = batch_groups;
    assign mac_valid_o    = (state == ISSUE);
    assign conv_row_o     = win_row;
    assign conv_col_o     = win_col;
    assign busy_o         = (state != IDLE);
    assign done_o         = (state == DONE);

    a_wgt_fit: assert property (@(posedge clk) disable iff (!rst)
        (state != IDLE) |-> (wgt_total <= 12'(WBUF_WORDS)))
        else $error("weights of %0d words exceed the buffer", wgt_total);

    // every batch carries at least one output channel
    a_batch_groups: assert property (@(posedge clk) disable iff (!rst)
        mac_valid_o |-> (batch_groups != '0))
        else $error("MAC batch issued without groups");

endmodule

//--- patch_gather.sv
`timescale 1ns/1ns

module patch_gather (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   patch_wr_i,
    input  conv_pkg::slot_t        patch_slot_i,
    input  conv_pkg::word_t        img_data_i,
    input  conv_pkg::conv_shape_t  shape_i,
    input  conv_pkg::chan_t        in_channel_i,
    input  conv_pkg::group_count_t batch_groups_i,
    output conv_pkg::lanes_t       data_mac_o
);
    import conv_pkg::*;

    // one image word per kernel position
    word_t patch_mem [WBUF_WORDS];

    always_ff @(posedge clk) begin
        if (patch_wr_i) begin
            patch_mem[patch_slot_i[BUF_IDX_W-1:0]] <= img_data_i;
        end
    end

    // walk the lanes in group, slot, channel order
    always_comb begin
        slot_t      s;
        logic [2:0] ch;
        logic [6:0] g;
        data_mac_o = '0;
        s  = '0;
        ch = '0;
        g  = '0;
        for (int l = 0; l < MAC_LANES; l++) begin
            if (g < 7'(batch_groups_i)) begin
                data_mac_o[l*DATA_W +: DATA_W] =
                    patch_mem[s[BUF_IDX_W-1:0]][ch*DATA_W +: DATA_W];
            end
            if ({1'b0, ch} == in_channel_i - chan_t'(1)) begin
                ch = '0;
                if ({1'b0, s} == shape_i.ker_area - dim_t'(1)) begin
                    s = '0;
                    g = g + 7'd1;
                end else begin
                    s = s + slot_t'(1);
                end
            end else begin
                ch = ch + 3'd1;
            end
        end
    end

    // image writes stay inside the current kernel window
    a_patch_slot: assert property (@(posedge clk) disable iff (!rst)
        patch_wr_i |-> ({1'b0, patch_slot_i} < shape_i.ker_area))
        else $error("patch slot %0d outside the kernel", patch_slot_i);

endmodule

//--- weight_buffer.sv
`timescale 1ns/1ns

module weight_buffer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wgt_wr_i,
    input  conv_pkg::slot_t        wgt_slot_i,
    input  conv_pkg::word_t        wgt_data_i,
    input  conv_pkg::conv_shape_t  shape_i,
    input  conv_pkg::chan_t        in_channel_i,
    input  conv_pkg::chan_t        oc_base_i,
    input  conv_pkg::group_count_t batch_groups_i,
    output conv_pkg::lanes_t       weight_mac_o
);
    import conv_pkg::*;

    // loaded once per layer, word index is out channel times area plus position
    word_t wbuf [WBUF_WORDS];

    always_ff @(posedge clk) begin
        if (wgt_wr_i) begin
            wbuf[wgt_slot_i[BUF_IDX_W-1:0]] <= wgt_data_i;
        end
    end

    // same lane order as the patch, word pointer runs across channels
    always_comb begin
        slot_t      s;
        slot_t      w;
        logic [2:0] ch;
        logic [6:0] g;
        weight_mac_o = '0;
        s  = '0;
        ch = '0;
        g  = '0;
        w  = slot_t'(oc_base_i) * slot_t'(shape_i.ker_area);
        for (int l = 0; l < MAC_LANES; l++) begin
            if (g < 7'(batch_groups_i)) begin
                weight_mac_o[l*DATA_W +: DATA_W] =
                    wbuf[w[BUF_IDX_W-1:0]][ch*DATA_W +: DATA_W];
            end
            if ({1'b0, ch} == in_channel_i - chan_t'(1)) begin
                ch = '0;
                w  = w + slot_t'(1);
                if ({1'b0, s} == shape_i.ker_area - dim_t'(1)) begin
                    s = '0;
                    // next output channel starts right after this one
                    g = g + 7'd1;
                end else begin
                    s = s + slot_t'(1);
                end
            end else begin
                ch = ch + 3'd1;
            end
        end
    end

    a_wgt_slot: assert property (@(posedge clk) disable iff (!rst)
        wgt_wr_i |-> (wgt_slot_i < slot_t'(WBUF_WORDS)))
        else $error("weight slot %0d beyond the buffer", wgt_slot_i);

endmodule

//--- conv_feeder_top.sv
`timescale 1ns/1ns

module conv_feeder_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   init_i,
    input  logic                   start_i,
    input  conv_pkg::conv_cfg_t    cfg_i,
    input  conv_pkg::word_t        img_data_i,
    input  conv_pkg::word_t        wgt_data_i,
    output conv_pkg::mem_req_t     img_req_o,
    output conv_pkg::mem_req_t     wgt_req_o,
    output logic                   mac_valid_o,
    output conv_pkg::lanes_t       data_mac_o,
    output conv_pkg::lanes_t       weight_mac_o,
    output conv_pkg::group_count_t num_groups_o,
    output conv_pkg::mac_counts_t  num_macs_o,
    output conv_pkg::dim_t         conv_row_o,
    output conv_pkg::dim_t         conv_col_o,
    output logic                   busy_o,
    output logic                   done_o
);
    import conv_pkg::*;

    conv_cfg_t    cfg;
    conv_shape_t  shape;
    logic         patch_wr;
    slot_t        patch_slot;
    logic         wgt_wr;
    slot_t        wgt_slot;
    chan_t        oc_base;
    group_count_t batch_groups;

    conv_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .init_i         (init_i),
        .start_i        (start_i),
        .cfg_i          (cfg_i),
        .shape_i        (shape),
        .cfg_o          (cfg),
        .img_req_o      (img_req_o),
        .wgt_req_o      (wgt_req_o),
        .patch_wr_o     (patch_wr),
        .patch_slot_o   (patch_slot),
        .wgt_wr_o       (wgt_wr),
        .wgt_slot_o     (wgt_slot),
        .oc_base_o      (oc_base),
        .batch_groups_o (batch_groups),
        .num_macs_o     (num_macs_o),
        .mac_valid_o    (mac_valid_o),
        .conv_row_o     (conv_row_o),
        .conv_col_o     (conv_col_o),
        .busy_o         (busy_o),
        .done_o         (done_o)
    );

    conv_shape u_shape (
        .cfg_i   (cfg),
        .shape_o (shape)
    );

    patch_gather u_patch (
        .clk            (clk),
        .rst            (rst),
        .patch_wr_i     (patch_wr),
        .patch_slot_i   (patch_slot),
        .img_data_i     (img_data_i),
        .shape_i        (shape),
        .in_channel_i   (cfg.in_channel),
        .batch_groups_i (batch_groups),
        .data_mac_o     (data_mac_o)
    );

    weight_buffer u_wbuf (
        .clk            (clk),
        .rst            (rst),
        .wgt_wr_i       (wgt_wr),
        .wgt_slot_i     (wgt_slot),
        .wgt_data_i     (wgt_data_i),
        .shape_i        (shape),
        .in_channel_i   (cfg.in_channel),
        .oc_base_i      (oc_base),
        .batch_groups_i (batch_groups),
        .weight_mac_o   (weight_mac_o)
    );

    assign num_groups_o = batch_groups;

endmodule

//--- tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    // active low reset for two rising edges, released on a falling edge
    initial begin
        rst_o = 1'b0;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b1;
    end

endmodule

//--- conv_tb.sv
`timescale 1ns/1ns

module conv_tb;
    import conv_pkg::*;

    localparam int N_CFG     = 5;
    localparam int ABORT_ROW = 1;
    localparam int IMG_WORDS = 256;

    logic         clk;
    logic         rst;
    logic         init_i;
    logic         start_i;
    conv_cfg_t    cfg_i;
    word_t        img_data;
    word_t        wgt_data;
    mem_req_t     img_req;
    mem_req_t     wgt_req;
    logic         mac_valid;
    lanes_t       data_mac;
    lanes_t       weight_mac;
    group_count_t num_groups;
    mac_counts_t  num_macs;
    dim_t         conv_row;
    dim_t         conv_col;
    logic         busy;
    logic         done;

    conv_cfg_t cfg_tab [N_CFG];
    int        exp_pulses [N_CFG];
    word_t     img_mem [IMG_WORDS];
    word_t     wgt_mem [WBUF_WORDS];
    logic      img_rd_q    = 1'b0;
    logic      wgt_rd_q    = 1'b0;
    addr_t     img_addr_q  = '0;
    addr_t     wgt_addr_q  = '0;
    int        seed;
    int        cycle_cnt   = 0;
    int        cycle_limit = 1000000;

    tb_clock u_clock (
        .clk_o (clk),
        .rst_o (rst)
    );

    conv_feeder_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .init_i       (init_i),
        .start_i      (start_i),
        .cfg_i        (cfg_i),
        .img_data_i   (img_data),
        .wgt_data_i   (wgt_data),
        .img_req_o    (img_req),
        .wgt_req_o    (wgt_req),
        .mac_valid_o  (mac_valid),
        .data_mac_o   (data_mac),
        .weight_mac_o (weight_mac),
        .num_groups_o (num_groups),
        .num_macs_o   (num_macs),
        .conv_row_o   (conv_row),
        .conv_col_o   (conv_col),
        .busy_o       (busy),
        .done_o       (done)
    );

    // SRAM models with one cycle of read latency
    always @(posedge clk) begin
        img_rd_q   <= img_req.rd;
        img_addr_q <= img_req.addr;
        wgt_rd_q   <= wgt_req.rd;
        wgt_addr_q <= wgt_req.addr;
    end

    always @(negedge clk) begin
        if (img_rd_q) begin
            img_data = img_mem[img_addr_q[7:0]];
        end
        if (wgt_rd_q) begin
            wgt_data = wgt_mem[wgt_addr_q[5:0]];
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input lanes_t exp_val, input lanes_t act_val);
        if (exp_val !== act_val) begin
            stop_run($sformatf("FAIL %s expected %0h actual %0h", name, exp_val, act_val));
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            stop_run($sformatf("timeout after %0d cycles without done", cycle_cnt));
        end
    end

    function automatic int groups_max(input conv_cfg_t c);
        int gm;
        gm = 64 / (int'(c.ker_row) * int'(c.ker_col) * int'(c.in_channel));
        return (gm > MAX_GROUPS) ? MAX_GROUPS : gm;
    endfunction

    // weight reads plus per window the patch reads, drain and batches
    function automatic int layer_cycles(input conv_cfg_t c);
        int area;
        int wins;
        int batches;
        area    = int'(c.ker_row) * int'(c.ker_col);
        wins    = ((int'(c.img_row) - int'(c.ker_row)) / int'(c.stride_row) + 1)
                * ((int'(c.img_col) - int'(c.ker_col)) / int'(c.stride_col) + 1);
        batches = (int'(c.out_channel) + groups_max(c) - 1) / groups_max(c);
        return int'(c.out_channel) * area + wins * (area + 2 + batches);
    endfunction

    // lane gi*tm + s*ic + ch carries byte ch of kernel position s
    function automatic lanes_t expect_data(input conv_cfg_t c, input int g, input int wr,
                                           input int wc);
        lanes_t     v;
        word_t      w;
        logic [7:0] a;
        int         kc;
        int         ic;
        int         area;
        int         lane;
        v    = '0;
        kc   = int'(c.ker_col);
        ic   = int'(c.in_channel);
        area = int'(c.ker_row) * kc;
        for (int gi = 0; gi < g; gi++) begin
            for (int s = 0; s < area; s++) begin
                a = 8'((wr + s / kc) * int'(c.img_col) + wc + s % kc);
                w = img_mem[a];
                for (int ch = 0; ch < ic; ch++) begin
                    lane = gi * area * ic + s * ic + ch;
                    v[lane*DATA_W +: DATA_W] = w[ch*DATA_W +: DATA_W];
                end
            end
        end
        return v;
    endfunction

    function automatic lanes_t expect_weights(input conv_cfg_t c, input int g, input int ob);
        lanes_t     v;
        word_t      w;
        logic [5:0] a;
        int         ic;
        int         area;
        int         lane;
        v    = '0;
        ic   = int'(c.in_channel);
        area = int'(c.ker_row) * int'(c.ker_col);
        for (int gi = 0; gi < g; gi++) begin
            for (int s = 0; s < area; s++) begin
                a = 6'((ob + gi) * area + s);
                w = wgt_mem[a];
                for (int ch = 0; ch < ic; ch++) begin
                    lane = gi * area * ic + s * ic + ch;
                    v[lane*DATA_W +: DATA_W] = w[ch*DATA_W +: DATA_W];
                end
            end
        end
        return v;
    endfunction

    function automatic mac_counts_t expect_macs(input int g, input int tm);
        mac_counts_t v;
        v = '0;
        for (int gi = 0; gi < g; gi++) begin
            v[gi*$bits(mac_count_t) +: $bits(mac_count_t)] = mac_count_t'(tm);
        end
        return v;
    endfunction

    task automatic fill_memories();
        for (int i = 0; i < IMG_WORDS; i++) begin
            img_mem[i] = {$random(seed), $random(seed)};
        end
        for (int i = 0; i < WBUF_WORDS; i++) begin
            wgt_mem[i] = {$random(seed), $random(seed)};
        end
    endtask

    task automatic start_layer(input conv_cfg_t c);
        @(negedge clk);
        cfg_i   = c;
        start_i = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
    endtask

    task automatic run_layer(input int row);
        conv_cfg_t c;
        string     name;
        int        ocol;
        int        tm;
        int        gmax;
        int        oc;
        int        g;
        int        er;
        int        ec;
        int        ob;
        int        idx;
        logic      finished;
        c        = cfg_tab[row];
        ocol     = (int'(c.img_col) - int'(c.ker_col)) / int'(c.stride_col) + 1;
        tm       = int'(c.ker_row) * int'(c.ker_col) * int'(c.in_channel);
        gmax     = groups_max(c);
        oc       = int'(c.out_channel);
        er       = 0;
        ec       = 0;
        ob       = 0;
        idx      = 0;
        finished = 1'b0;
        start_layer(c);
        while (!finished) begin
            @(negedge clk);
            // the feeder stays busy from start through the done cycle
            check_value($sformatf("row%0d busy", row), lanes_t'(1), lanes_t'(busy));
            if (mac_valid && idx >= exp_pulses[row]) begin
                stop_run($sformatf("row %0d issued more than %0d MAC batches", row, idx));
            end else if (mac_valid) begin
                g    = (oc - ob < gmax) ? oc - ob : gmax;
                name = $sformatf("row%0d pulse%0d", row, idx);
                check_value({name, " groups"}, lanes_t'(g), lanes_t'(num_groups));
                check_value({name, " macs"}, lanes_t'(expect_macs(g, tm)), lanes_t'(num_macs));
                check_value({name, " row"}, lanes_t'(er * int'(c.stride_row)), lanes_t'(conv_row));
                check_value({name, " col"}, lanes_t'(ec * int'(c.stride_col)), lanes_t'(conv_col));
                check_value({name, " data"},
                    expect_data(c, g, er * int'(c.stride_row), ec * int'(c.stride_col)), data_mac);
                check_value({name, " weights"}, expect_weights(c, g, ob), weight_mac);
                // next batch, then next window in raster order
                ob = ob + g;
                if (ob == oc) begin
                    ob = 0;
                    ec = ec + 1;
                    if (ec == ocol) begin
                        ec = 0;
                        er = er + 1;
                    end
                end
                idx = idx + 1;
            end
            if (done) begin
                check_value($sformatf("row%0d pulse count", row),
                    lanes_t'(exp_pulses[row]), lanes_t'(idx));
                finished = 1'b1;
            end
        end
        @(negedge clk);
        check_value($sformatf("row%0d done width", row), '0, lanes_t'(done));
        check_value($sformatf("row%0d idle busy", row), '0, lanes_t'(busy));
    endtask

    // init in the middle of a run must silence the feeder
    task automatic abort_layer(input int row);
        int seen;
        seen = 0;
        start_layer(cfg_tab[row]);
        while (seen < 3) begin
            @(negedge clk);
            if (mac_valid) begin
                seen = seen + 1;
            end
        end
        init_i = 1'b1;
        @(negedge clk);
        init_i = 1'b0;
        repeat (30) begin
            check_value("abort mac_valid", '0, lanes_t'(mac_valid));
            check_value("abort done", '0, lanes_t'(done));
            check_value("abort busy", '0, lanes_t'(busy));
            @(negedge clk);
        end
    endtask

    initial begin
        int total;
        init_i   = 1'b0;
        start_i  = 1'b0;
        cfg_i    = '0;
        img_data = '0;
        wgt_data = '0;
        seed     = 64268;

        // img_row img_col ker_row ker_col in_ch out_ch stride_row stride_col
        cfg_tab[0] = '{8'd3, 8'd4, 8'd1, 8'd1, 4'd8, 4'd10, 4'd1, 4'd1};
        cfg_tab[1] = '{8'd5, 8'd5, 8'd3, 8'd3, 4'd2, 4'd5, 4'd1, 4'd1};
        cfg_tab[2] = '{8'd6, 8'd7, 8'd2, 8'd2, 4'd4, 4'd6, 4'd2, 4'd2};
        cfg_tab[3] = '{8'd4, 8'd6, 8'd2, 8'd4, 4'd8, 4'd2, 4'd1, 4'd2};
        cfg_tab[4] = '{8'd3, 8'd5, 8'd1, 8'd2, 4'd3, 4'd7, 4'd1, 4'd1};
        // windows times batches per window
        exp_pulses[0] = 24;
        exp_pulses[1] = 18;
        exp_pulses[2] = 18;
        exp_pulses[3] = 12;
        exp_pulses[4] = 12;

        total = 0;
        for (int r = 0; r < N_CFG; r++) begin
            total = total + layer_cycles(cfg_tab[r]);
        end
        // the abort row runs twice more
        total       = total + 2 * layer_cycles(cfg_tab[ABORT_ROW]);
        cycle_limit = 2 * total + 100;

        wait (rst === 1'b1);
        @(negedge clk);
        check_value("reset mac_valid", '0, lanes_t'(mac_valid));
        check_value("reset done", '0, lanes_t'(done));
        check_value("reset busy", '0, lanes_t'(busy));
        check_value("reset img rd", '0, lanes_t'(img_req.rd));
        check_value("reset wgt rd", '0, lanes_t'(wgt_req.rd));

        for (int r = 0; r < N_CFG; r++) begin
            fill_memories();
            run_layer(r);
        end
        fill_memories();
        abort_layer(ABORT_ROW);
        run_layer(ABORT_ROW);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- filelist.f
conv_pkg.sv
conv_shape.sv
conv_ctrl.sv
patch_gather.sv
weight_buffer.sv
conv_feeder_top.sv
tb_clock.sv
conv_tb.sv

//--- Makefile
SIM = obj_dir/conv_tb

all: run

run:
	verilator --binary --timing --assert -f filelist.f --top-module conv_tb -o conv_tb
	./$(SIM)

lint:
	verilator --lint-only --timing --assert -Wall -f filelist.f --top-module conv_feeder_top

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
